//--- src.f
src/cachePkg.sv
src/cacheCtrl.sv
src/tagStore.sv
src/dataStore.sv
src/memPort.sv
src/cacheL1Top.sv
tb/cacheL1_props.sv
tb/memModel.sv
tb/cacheTb.sv

//--- src/cacheCtrl.sv
`timescale 1ns/1ps
// Cache control FSM that classifies requests and sequences fills, writes and replies.
module cacheCtrl
  import cachePkg::*;
(
  input  logic              clk,
  input  logic              arstN,
  input  logic              cpuReqValid,
  output logic              cpuReqReady,
  input  cpuReqT            cpuReq,
  output logic              cpuRspValid,
  output cpuRspT            cpuRsp,
  input  logic              hit,
  output cacheAddrT         lookupAddr,
  output logic              tagFillEn,
  output logic              tagInvalEn,
  output cacheAddrT         fillAddr,
  output logic [indexW-1:0] dataRdIndex,
  input  logic [dataW-1:0]  dataRd,
  output logic              dataFillEn,
  output logic [dataW-1:0]  dataFillWord,
  output logic              issueValid,
  input  logic              issueReady,
  output memReqT            issueReq,
  input  logic              doneValid,
  input  logic [dataW-1:0]  doneData
);

  typedef enum logic [2:0] {
    stIdle,
    stHitReply,
    stUncReply,
    stIssue,
    stWait,
    stReply
  } stateT;

  stateT            state;
  stateT            stateNext;
  cpuReqT           reqQ;
  cpuReqT           issueSrc;
  logic             wasHitQ;
  logic [dataW-1:0] rspDataQ;
  logic             accept;
  logic             needMem;
  logic             waitDone;

  assign cpuReqReady = (state == stIdle);
  assign accept      = cpuReqValid && cpuReqReady;
  assign needMem     = !cpuReq.addr.fields.uncached && (cpuReq.write || !hit);

  // lookup and data read run on the incoming request.
  assign lookupAddr  = cpuReq.addr;
  assign dataRdIndex = cpuReq.addr.fields.index;

  // issue straight from the port on acceptance, else from the held copy.
  assign issueSrc   = (state == stIdle) ? cpuReq : reqQ;
  assign issueValid = (accept && needMem) || (state == stIssue);
  assign issueReq   = '{addr: issueSrc.addr.raw, write: issueSrc.write, wdata: issueSrc.wdata};

  assign waitDone     = (state == stWait) && doneValid;
  assign fillAddr     = reqQ.addr;
  assign tagFillEn    = waitDone && !reqQ.write;
  assign dataFillEn   = waitDone && !reqQ.write;
  assign dataFillWord = doneData;
  // write hit drops the line instead of updating it.
  assign tagInvalEn   = waitDone && reqQ.write && wasHitQ;

  assign cpuRspValid = (state == stReply);
  assign cpuRsp      = '{rdata: rspDataQ};

  always_comb begin
    stateNext = state;
    case (state)
      stIdle: begin
        if (accept) begin
          if (cpuReq.addr.fields.uncached) begin
            stateNext = stUncReply;
          end else if (!needMem) begin
            stateNext = stHitReply;
          end else if (issueReady) begin
            stateNext = stWait;
          end else begin
            stateNext = stIssue;
          end
        end
      end
      stHitReply: stateNext = stReply;
      stUncReply: stateNext = stReply;
      stIssue: begin
        if (issueReady) begin
          stateNext = stWait;
        end
      end
      stWait: begin
        if (doneValid) begin
          stateNext = stReply;
        end
      end
      default: stateNext = stIdle;
    endcase
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      state <= stIdle;
    end else begin
      state <= stateNext;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      reqQ    <= cpuReq;
      wasHitQ <= hit;
    end
    if (state == stHitReply) begin
      rspDataQ <= dataRd;
    end else if (state == stUncReply) begin
      rspDataQ <= '0;
    end else if (waitDone) begin
      rspDataQ <= reqQ.write ? '0 : doneData;
    end
  end

endmodule

//--- src/cacheL1Top.sv
`timescale 1ns/1ps
// Direct-mapped write-through L1 cache top joining controller, stores and memory port.
module cacheL1Top
  import cachePkg::*;
(
  input  logic   clk,
  input  logic   arstN,
  input  logic   cpuReqValid,
  output logic   cpuReqReady,
  input  cpuReqT cpuReq,
  output logic   cpuRspValid,
  output cpuRspT cpuRsp,
  output logic   memReqValid,
  input  logic   memReqReady,
  output memReqT memReq,
  input  logic   memRspValid,
  input  memRspT memRsp
);

  logic              hit;
  cacheAddrT         lookupAddr;
  logic              tagFillEn;
  logic              tagInvalEn;
  cacheAddrT         fillAddr;
  logic [indexW-1:0] dataRdIndex;
  logic [dataW-1:0]  dataRd;
  logic              dataFillEn;
  logic [dataW-1:0]  dataFillWord;
  logic              issueValid;
  logic              issueReady;
  memReqT            issueReq;
  logic              doneValid;
  logic [dataW-1:0]  doneData;

  cacheCtrl u_ctrl (
    .clk          (clk),
    .arstN        (arstN),
    .cpuReqValid  (cpuReqValid),
    .cpuReqReady  (cpuReqReady),
    .cpuReq       (cpuReq),
    .cpuRspValid  (cpuRspValid),
    .cpuRsp       (cpuRsp),
    .hit          (hit),
    .lookupAddr   (lookupAddr),
    .tagFillEn    (tagFillEn),
    .tagInvalEn   (tagInvalEn),
    .fillAddr     (fillAddr),
    .dataRdIndex  (dataRdIndex),
    .dataRd       (dataRd),
    .dataFillEn   (dataFillEn),
    .dataFillWord (dataFillWord),
    .issueValid   (issueValid),
    .issueReady   (issueReady),
    .issueReq     (issueReq),
    .doneValid    (doneValid),
    .doneData     (doneData)
  );

  tagStore u_tags (
    .clk        (clk),
    .arstN      (arstN),
    .lookupAddr (lookupAddr),
    .hit        (hit),
    .fillEn     (tagFillEn),
    .invalEn    (tagInvalEn),
    .fillAddr   (fillAddr)
  );

  dataStore u_data (
    .clk       (clk),
    .rdIndex   (dataRdIndex),
    .rdData    (dataRd),
    .fillEn    (dataFillEn),
    .fillIndex (fillAddr.fields.index),
    .fillWord  (dataFillWord)
  );

  memPort u_mem (
    .clk         (clk),
    .arstN       (arstN),
    .issueValid  (issueValid),
    .issueReady  (issueReady),
    .issueReq    (issueReq),
    .memReqValid (memReqValid),
    .memReqReady (memReqReady),
    .memReq      (memReq),
    .memRspValid (memRspValid),
    .memRsp      (memRsp),
    .doneValid   (doneValid),
    .doneData    (doneData)
  );

endmodule

//--- src/cachePkg.sv
// Shared geometry, address views and port payload types for the L1 cache.
package cachePkg;

  localparam int addrW    = 32;
  localparam int dataW    = 32;
  localparam int numLines = 32;
  localparam int indexW   = 5;
  localparam int tagW     = 4;
  localparam int offsetW  = 2;

  // bits between the uncached flag and the tag.
  localparam int unusedW  = addrW - 1 - tagW - indexW - offsetW;

  typedef struct packed {
    logic               uncached;
    logic [unusedW-1:0] unused;
    logic [tagW-1:0]    tag;
    logic [indexW-1:0]  index;
    logic [offsetW-1:0] offset;
  } cacheAddrFieldsT;

  // same word, seen raw or split into lookup fields.
  typedef union packed {
    logic [addrW-1:0] raw;
    cacheAddrFieldsT  fields;
  } cacheAddrT;

  typedef struct packed {
    cacheAddrT        addr;
    logic             write;
    logic [dataW-1:0] wdata;
  } cpuReqT;

  typedef struct packed {
    logic [dataW-1:0] rdata;
  } cpuRspT;

  typedef struct packed {
    logic [addrW-1:0] addr;
    logic             write;
    logic [dataW-1:0] wdata;
  } memReqT;

  // for a write this is only an acknowledgement.
  typedef struct packed {
    logic [dataW-1:0] rdata;
  } memRspT;

endpackage

//--- src/dataStore.sv
`timescale 1ns/1ps
// Cache data word array with a registered read port and a fill write port.
module dataStore
  import cachePkg::*;
(
  input  logic              clk,
  input  logic [indexW-1:0] rdIndex,
  output logic [dataW-1:0]  rdData,
  input  logic              fillEn,
  input  logic [indexW-1:0] fillIndex,
  input  logic [dataW-1:0]  fillWord
);

  logic [dataW-1:0] words [numLines];

  always_ff @(posedge clk) begin
    if (fillEn) begin
      words[fillIndex] <= fillWord;
    end
  end

  // registered so hit data lines up with the reply cycle.
  always_ff @(posedge clk) begin
    rdData <= words[rdIndex];
  end

endmodule

//--- src/memPort.sv
`timescale 1ns/1ps
// Memory request register that holds one request through stalls and waits for its response.
module memPort
  import cachePkg::*;
(
  input  logic             clk,
  input  logic             arstN,
  input  logic             issueValid,
  output logic             issueReady,
  input  memReqT           issueReq,
  output logic             memReqValid,
  input  logic             memReqReady,
  output memReqT           memReq,
  input  logic             memRspValid,
  input  memRspT           memRsp,
  output logic             doneValid,
  output logic [dataW-1:0] doneData
);

  logic   reqValidQ;
  logic   pendingQ;
  logic   awaitRsp;
  memReqT reqQ;

  // request accepted by memory, response not yet back.
  assign awaitRsp = pendingQ && !reqValidQ;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      reqValidQ <= 1'b0;
      pendingQ  <= 1'b0;
    end else if (issueValid && issueReady) begin
      reqValidQ <= 1'b1;
      pendingQ  <= 1'b1;
    end else begin
      if (reqValidQ && memReqReady) begin
        reqValidQ <= 1'b0;
      end
      if (awaitRsp && memRspValid) begin
        pendingQ <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (issueValid && issueReady) begin
      reqQ <= issueReq;
    end
  end

  assign issueReady  = !pendingQ;
  assign memReqValid = reqValidQ;
  assign memReq      = reqQ;
  assign doneValid   = awaitRsp && memRspValid;
  assign doneData    = memRsp.rdata;

endmodule

//--- src/tagStore.sv
`timescale 1ns/1ps
// Per-line valid bits and tags with combinational lookup, fill and invalidate.
module tagStore
  import cachePkg::*;
(
  input  logic      clk,
  input  logic      arstN,
  input  cacheAddrT lookupAddr,
  output logic      hit,
  input  logic      fillEn,
  input  logic      invalEn,
  input  cacheAddrT fillAddr
);

  logic [numLines-1:0] valid;
  logic [tagW-1:0]     tags [numLines];

  // valid bits are the only state that needs clearing.
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      valid <= '0;
    end else if (fillEn) begin
      valid[fillAddr.fields.index] <= 1'b1;
    end else if (invalEn) begin
      valid[fillAddr.fields.index] <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (fillEn) begin
      tags[fillAddr.fields.index] <= fillAddr.fields.tag;
    end
  end

  assign hit = valid[lookupAddr.fields.index] &&
               (tags[lookupAddr.fields.index] == lookupAddr.fields.tag);

endmodule

//--- tb/cacheL1_props.sv
`timescale 1ns/1ps
// Bound checks on cache reply timing, memory traffic and handshake stability.
module cacheL1_props
  import cachePkg::*;
(
  input logic   clk,
  input logic   arstN,
  input logic   cpuReqValid,
  input logic   cpuReqReady,
  input cpuReqT cpuReq,
  input logic   cpuRspValid,
  input cpuRspT cpuRsp,
  input logic   memReqValid,
  input logic   memReqReady,
  input memReqT memReq,
  input logic   hit
);

  logic accept;
  logic busy;
  int   errCount = 0;

  assign accept = cpuReqValid && cpuReqReady;

  // set on acceptance, cleared after the response cycle.
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      busy <= 1'b0;
    end else if (accept) begin
      busy <= 1'b1;
    end else if (cpuRspValid) begin
      busy <= 1'b0;
    end
  end

  // read hit answers from the store, memory stays idle.
  hitTiming: assert property (@(posedge clk) disable iff (!arstN)
    accept && !cpuReq.write && !cpuReq.addr.fields.uncached && hit
    |=> (!memReqValid && !cpuRspValid) ##1 (cpuRspValid && !memReqValid))
    else begin
      $error("read hit was not answered one cycle after acceptance");
      errCount++;
    end

  uncachedTiming: assert property (@(posedge clk) disable iff (!arstN)
    accept && cpuReq.addr.fields.uncached
    |=> (!memReqValid && !cpuRspValid) ##1 (cpuRspValid && !memReqValid && cpuRsp.rdata == '0))
    else begin
      $error("uncached request was slow, nonzero or touched memory");
      errCount++;
    end

  writeThrough: assert property (@(posedge clk) disable iff (!arstN)
    accept && cpuReq.write && !cpuReq.addr.fields.uncached
    |=> memReqValid && memReq.write && memReq.addr == $past(cpuReq.addr.raw) &&
        memReq.wdata == $past(cpuReq.wdata))
    else begin
      $error("write was not presented to memory with its address and data");
      errCount++;
    end

  // held request must not move while memory stalls.
  reqStable: assert property (@(posedge clk) disable iff (!arstN)
    memReqValid && !memReqReady |=> memReqValid && $stable(memReq))
    else begin
      $error("memory request changed or dropped under back-pressure");
      errCount++;
    end

  busyNotReady: assert property (@(posedge clk) disable iff (!arstN)
    busy || cpuRspValid |-> busy && !cpuReqReady)
    else begin
      $error("request side was ready in flight or answered without a request");
      errCount++;
    end

endmodule

bind cacheL1Top cacheL1_props u_props (.*);

//--- tb/cacheTb.sv
`timescale 1ns/1ps
// Testbench for the L1 cache, directed and random requests against a shadow memory.
module cacheTb
  import cachePkg::*;
();

  logic   clk;
  logic   arstN;
  logic   cpuReqValid;
  logic   cpuReqReady;
  cpuReqT cpuReq;
  logic   cpuRspValid;
  cpuRspT cpuRsp;
  logic   memReqValid;
  logic   memReqReady;
  memReqT memReq;
  logic   memRspValid;
  memRspT memRsp;

  int errors = 0;
  int cycles = 0;
  // about 60 requests at up to 50 cycles each.
  int cycleLimit = 3000;

  logic [dataW-1:0]    shadow [logic [addrW-1:0]];
  logic [numLines-1:0] shValid;
  logic [tagW-1:0]     shTag [numLines];

  cacheL1Top u_dut (.*);

  memModel u_memModel (.*);

  always #4 clk = ~clk;

  always @(posedge clk) begin
    cycles++;
    if (cycles >= cycleLimit) begin
      $display("Timeout: run did not finish within %0d cycles", cycleLimit);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  function automatic logic [dataW-1:0] memWord(input logic [addrW-1:0] addr);
    if (shadow.exists(addr)) begin
      return shadow[addr];
    end
    return addr ^ 32'hc0de0000;
  endfunction

  task automatic checkData(input string name, input logic [dataW-1:0] exp,
                           input logic [dataW-1:0] act);
    assert (act === exp) else begin
      errors++;
      $display("Mismatch in %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic checkTiming(input string name, input logic ok, input string what);
    assert (ok) else begin
      errors++;
      $display("Timing error in %s: %s", name, what);
    end
  endtask

  task automatic doRequest(input string name, input logic [addrW-1:0] addr,
                           input logic wr, input logic [dataW-1:0] wd);
    cacheAddrT        a;
    logic             lineHit;
    logic             sawMem;
    int               lat;
    logic [dataW-1:0] rsp;
    a.raw   = addr;
    lineHit = shValid[a.fields.index] && (shTag[a.fields.index] == a.fields.tag);
    #1;
    cpuReqValid = 1'b1;
    cpuReq      = '{addr: a, write: wr, wdata: wd};
    do begin
      @(posedge clk);
    end while (!cpuReqReady);
    #1;
    cpuReqValid = 1'b0;
    lat         = 0;
    sawMem      = 1'b0;
    do begin
      @(posedge clk);
      lat++;
      sawMem = sawMem || memReqValid;
    end while (!cpuRspValid);
    rsp = cpuRsp.rdata;
    if (a.fields.uncached) begin
      checkTiming(name, lat == 2 && !sawMem, "uncached request was slow or touched memory");
      checkData(name, '0, rsp);
    end else if (wr) begin
      checkTiming(name, sawMem, "write was not sent to memory");
      shadow[addr] = wd;
      // a write hit drops the line.
      if (lineHit) begin
        shValid[a.fields.index] = 1'b0;
      end
    end else begin
      checkData(name, memWord(addr), rsp);
      if (lineHit) begin
        checkTiming(name, lat == 2 && !sawMem, "read hit not answered one cycle after accept");
      end else begin
        checkTiming(name, sawMem, "read miss made no memory request");
        shValid[a.fields.index] = 1'b1;
        shTag[a.fields.index]   = a.fields.tag;
      end
    end
  endtask

  initial begin : stimulus
    logic [addrW-1:0] addr;
    logic             wr;
    void'($urandom(32'h6b11dba7));
    clk         = 1'b0;
    arstN       = 1'b0;
    cpuReqValid = 1'b0;
    cpuReq      = '0;
    shValid     = '0;
    repeat (2) @(posedge clk);
    #1;
    arstN = 1'b1;
    @(posedge clk);

    doRequest("readMiss", 32'h0000010c, 1'b0, '0);
    doRequest("readHit", 32'h0000010c, 1'b0, '0);
    doRequest("writeHit", 32'h0000010c, 1'b1, 32'h12345678);
    doRequest("readAfterWrite", 32'h0000010c, 1'b0, '0);
    doRequest("writeMiss", 32'h00000200, 1'b1, 32'h0badf00d);
    doRequest("readAfterWriteMiss", 32'h00000200, 1'b0, '0);
    doRequest("uncached", 32'h80000040, 1'b0, '0);
    doRequest("uncachedWrite", 32'h80000044, 1'b1, 32'hffffffff);
    // same index, different tags.
    for (int i = 0; i < 3; i++) begin
      doRequest("evict", 32'h00000094, 1'b0, '0);
      doRequest("evict", 32'h00000314, 1'b0, '0);
    end

    for (int i = 0; i < 45; i++) begin
      addr = {($urandom_range(0, 9) == 0), 20'h0, 4'($urandom_range(0, 3)),
              5'($urandom_range(0, 7)), 2'b00};
      wr   = ($urandom_range(0, 3) == 0);
      doRequest("random", addr, wr, $urandom());
    end

    repeat (3) @(posedge clk);
    $display("Errors: %0d from data and timing checks, %0d from assertions",
             errors, u_dut.u_props.errCount);
    if (errors == 0 && u_dut.u_props.errCount == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

//--- tb/memModel.sv
`timescale 1ns/1ps
// Backing memory model with random request stalls and random response delay.
module memModel
  import cachePkg::*;
(
  input  logic   clk,
  input  logic   memReqValid,
  output logic   memReqReady,
  input  memReqT memReq,
  output logic   memRspValid,
  output memRspT memRsp
);

  logic [dataW-1:0] words [logic [addrW-1:0]];

  initial begin : serve
    logic             taken;
    logic             busy;
    int               delay;
    memReqT           req;
    logic [dataW-1:0] rspData;
    busy        = 1'b0;
    delay       = 0;
    rspData     = '0;
    memReqReady = 1'b0;
    memRspValid = 1'b0;
    memRsp      = '0;
    forever begin
      @(posedge clk);
      taken = memReqValid && memReqReady;
      req   = memReq;
      #1;
      memRspValid = 1'b0;
      if (taken) begin
        if (req.write) begin
          words[req.addr] = req.wdata;
        end
        rspData = words.exists(req.addr) ? words[req.addr] : req.addr ^ 32'hc0de0000;
        delay   = $urandom_range(0, 3);
        busy    = 1'b1;
      end else if (busy) begin
        if (delay == 0) begin
          memRspValid = 1'b1;
          memRsp      = '{rdata: rspData};
          busy        = 1'b0;
        end else begin
          delay--;
        end
      end
      // stall about a quarter of the cycles.
      memReqReady = ($urandom_range(0, 3) != 0);
    end
  end

endmodule
